// ==== design/meta_defs.svh ====
/*
 * Metadata command path sizes.
 * Region count, id width, memory geometry and queue depth, shared by
 * every RTL block of the subsystem.
 */

`ifndef META_DEFS_SVH
`define META_DEFS_SVH

// number of requesting regions and the width of a region id.
`define N_REGIONS 4
`define N_REGIONS_BITS 2

// shared memory word address and data widths.
`define ADDR_BITS 4
`define DATA_BITS 16

// the memory holds one word per address, so 16 words here.
`define MEM_WORDS (1 << `ADDR_BITS)

// entries per region queue and the matching pointer width.
`define QUEUE_DEPTH 4
`define QUEUE_PTR_BITS 2

`endif

// ==== design/meta_pkg.sv ====
/*
 * Metadata command path types.
 * Command opcodes carried from the regions to the memory engine, and the
 * state encoding of the engine FSM.
 */

package meta_pkg;

  // command opcode, one bit wide on every port that carries it.
  typedef enum logic [0:0] {
    OP_READ  = 1'b0, // returns one word with the issuing region id.
    OP_WRITE = 1'b1  // commits one word, no response.
  } opcode_t;

  // memory engine FSM.
  // a write completes in ST_IDLE.
  // a read walks through ST_READ and ST_RESP before the next command.
  typedef enum logic [1:0] {
    ST_IDLE = 2'b00, // accepting commands.
    ST_READ = 2'b01, // synchronous memory read of the latched address.
    ST_RESP = 2'b10  // response strobe is high for this one cycle.
  } engine_state_t;

endpackage

// ==== design/region_queue.sv ====
/*
 * Region command queue.
 * Small circular FIFO that buffers read and write commands of one region
 * between the outside requester and the round-robin arbiter. One command
 * can enter and one can leave in the same cycle.
 */

`include "meta_defs.svh"

module region_queue (
  input  logic                   aclk,
  input  logic                   aresetn,

  // requester side.
  input  logic                   req_valid,
  output logic                   req_ready,
  input  meta_pkg::opcode_t      req_op,
  input  logic [`ADDR_BITS-1:0]  req_addr,
  input  logic [`DATA_BITS-1:0]  req_wdata,

  // arbiter side.
  output logic                   q_valid,
  input  logic                   q_ready,
  output meta_pkg::opcode_t      q_op,
  output logic [`ADDR_BITS-1:0]  q_addr,
  output logic [`DATA_BITS-1:0]  q_wdata
);

  import meta_pkg::*;

  typedef logic [`QUEUE_PTR_BITS-1:0] ptr_t;
  typedef logic [`QUEUE_PTR_BITS:0]   cnt_t; // one bit wider, it has to reach QUEUE_DEPTH.

  // command storage, one slot per entry.
  opcode_t               op_mem    [`QUEUE_DEPTH];
  logic [`ADDR_BITS-1:0] addr_mem  [`QUEUE_DEPTH];
  logic [`DATA_BITS-1:0] wdata_mem [`QUEUE_DEPTH];

  ptr_t wr_ptr; // next free slot.
  ptr_t rd_ptr; // oldest command, presented to the arbiter.
  cnt_t count;  // number of occupied slots.

  logic push;
  logic pop;

  assign req_ready = (count != cnt_t'(`QUEUE_DEPTH)); // full only blocks the requester.
  assign q_valid   = (count != '0);

  assign push = req_valid & req_ready;
  assign pop  = q_valid & q_ready;

  // the head is read straight from storage, so a command shows up the cycle after its push.
  assign q_op    = op_mem[rd_ptr];
  assign q_addr  = addr_mem[rd_ptr];
  assign q_wdata = wdata_mem[rd_ptr];

  always_ff @(posedge aclk) begin
    if (push) begin
      op_mem[wr_ptr]    <= req_op;
      addr_mem[wr_ptr]  <= req_addr;
      wdata_mem[wr_ptr] <= req_wdata;
    end
  end

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == ptr_t'(`QUEUE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1; // wrap at the end.
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == ptr_t'(`QUEUE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      // a push and a pop together leave the count unchanged.
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

// ==== design/meta_arbiter.sv ====
/*
 * Round-robin command arbiter.
 * Picks one valid region per cycle, starting the scan at the priority
 * pointer, forwards its command to the memory engine with the granted id,
 * and moves the pointer to the region after the winner on each transfer.
 */

`include "meta_defs.svh"

module meta_arbiter #(
  parameter int N_ID      = `N_REGIONS,
  parameter int N_ID_BITS = `N_REGIONS_BITS
) (
  input  logic                             aclk,
  input  logic                             aresetn,

  // one lane per region.
  input  logic [N_ID-1:0]                  s_valid,
  output logic [N_ID-1:0]                  s_ready,
  input  meta_pkg::opcode_t [N_ID-1:0]     s_op,
  input  logic [N_ID-1:0][`ADDR_BITS-1:0]  s_addr,
  input  logic [N_ID-1:0][`DATA_BITS-1:0]  s_wdata,

  // granted command towards the engine.
  output logic                             m_valid,
  input  logic                             m_ready,
  output meta_pkg::opcode_t                m_op,
  output logic [`ADDR_BITS-1:0]            m_addr,
  output logic [`DATA_BITS-1:0]            m_wdata,

  output logic [N_ID_BITS-1:0]             id_out
);

  import meta_pkg::*;

  logic [N_ID_BITS-1:0] rr_ptr; // region with the highest priority this cycle.
  logic [N_ID_BITS-1:0] sel;    // winner of the scan.
  logic                 found;

  // scan from rr_ptr upwards with wrap, the first valid region wins.
  always_comb begin
    int unsigned idx;
    idx   = 0;
    sel   = '0;
    found = 1'b0;
    for (int i = 0; i < N_ID; i++) begin
      idx = (int'(rr_ptr) + i) % N_ID;
      if (!found && s_valid[idx]) begin
        found = 1'b1;
        sel   = N_ID_BITS'(idx);
      end
    end
  end

  assign m_valid = found;                          // no register between queue and engine.
  assign m_op    = found ? s_op[sel] : OP_READ;    // idle lane shows a harmless read.
  assign m_addr  = s_addr[sel];
  assign m_wdata = s_wdata[sel];
  assign id_out  = sel;

  // only the winner sees the engine's ready.
  always_comb begin
    s_ready      = '0;
    s_ready[sel] = m_ready & found;
  end

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      rr_ptr <= '0;
    end else if (m_valid && m_ready) begin
      // the winner drops to lowest priority, so every waiter is served within N_ID grants.
      rr_ptr <= (sel == N_ID_BITS'(N_ID - 1)) ? '0 : sel + 1'b1;
    end
  end

endmodule

// ==== design/mem_engine.sv ====
/*
 * Shared memory engine.
 * Executes one granted command at a time on the 16-word memory. Writes
 * commit at their transfer edge. Reads block new commands for two cycles
 * and end with a one-cycle response strobe tagged with the region id.
 */

`include "meta_defs.svh"

module mem_engine (
  input  logic                        aclk,
  input  logic                        aresetn,

  // granted command from the arbiter.
  input  logic                        cmd_valid,
  output logic                        cmd_ready,
  input  meta_pkg::opcode_t           cmd_op,
  input  logic [`ADDR_BITS-1:0]       cmd_addr,
  input  logic [`DATA_BITS-1:0]       cmd_wdata,
  input  logic [`N_REGIONS_BITS-1:0]  cmd_id,

  // read response, no back-pressure.
  output logic                        rsp_valid,
  output logic [`N_REGIONS_BITS-1:0]  rsp_id,
  output logic [`DATA_BITS-1:0]       rsp_data
);

  import meta_pkg::*;

  logic [`DATA_BITS-1:0] mem [`MEM_WORDS]; // the shared metadata words.

  engine_state_t state;
  engine_state_t state_next;

  logic [`ADDR_BITS-1:0] rd_addr; // address of the read in progress.

  logic cmd_fire;
  logic wr_fire;
  logic rd_fire;

  assign cmd_ready = (state == ST_IDLE); // stalled for the whole read.
  assign rsp_valid = (state == ST_RESP);

  assign cmd_fire = cmd_valid & cmd_ready;
  assign wr_fire  = cmd_fire & (cmd_op == OP_WRITE);
  assign rd_fire  = cmd_fire & (cmd_op == OP_READ);

  always_comb begin
    state_next = state;
    case (state)
      ST_IDLE: begin
        if (rd_fire) begin
          state_next = ST_READ; // writes stay here.
        end
      end
      ST_READ: state_next = ST_RESP;
      ST_RESP: state_next = ST_IDLE;
      default: state_next = ST_IDLE;
    endcase
  end

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      state <= ST_IDLE;
    end else begin
      state <= state_next;
    end
  end

  // memory write port, the word is in place at the transfer edge.
  always_ff @(posedge aclk) begin
    if (wr_fire) begin
      mem[cmd_addr] <= cmd_wdata;
    end
  end

  // latch the read's address and issuer, then fetch the word one cycle later.
  always_ff @(posedge aclk) begin
    if (rd_fire) begin
      rd_addr <= cmd_addr;
      rsp_id  <= cmd_id;   // held through ST_RESP.
    end
    if (state == ST_READ) begin
      rsp_data <= mem[rd_addr]; // valid while rsp_valid is high.
    end
  end

endmodule

// ==== design/meta_subsystem_top.sv ====
/*
 * Metadata command subsystem.
 * One command queue per region, a round-robin arbiter over the queues and
 * the shared memory engine, joined by plain wires.
 */

`include "meta_defs.svh"

module meta_subsystem_top (
  input  logic                                   aclk,
  input  logic                                   aresetn,

  // per-region requests.
  input  logic [`N_REGIONS-1:0]                  req_valid,
  output logic [`N_REGIONS-1:0]                  req_ready,
  input  meta_pkg::opcode_t [`N_REGIONS-1:0]     req_op,
  input  logic [`N_REGIONS-1:0][`ADDR_BITS-1:0]  req_addr,
  input  logic [`N_REGIONS-1:0][`DATA_BITS-1:0]  req_wdata,

  // read responses.
  output logic                                   rsp_valid,
  output logic [`N_REGIONS_BITS-1:0]             rsp_id,
  output logic [`DATA_BITS-1:0]                  rsp_data
);

  import meta_pkg::*;

  // queue heads towards the arbiter.
  logic [`N_REGIONS-1:0]                 q_valid;
  logic [`N_REGIONS-1:0]                 q_ready;
  opcode_t [`N_REGIONS-1:0]              q_op;
  logic [`N_REGIONS-1:0][`ADDR_BITS-1:0] q_addr;
  logic [`N_REGIONS-1:0][`DATA_BITS-1:0] q_wdata;

  // granted command towards the engine.
  logic                       cmd_valid;
  logic                       cmd_ready;
  opcode_t                    cmd_op;
  logic [`ADDR_BITS-1:0]      cmd_addr;
  logic [`DATA_BITS-1:0]      cmd_wdata;
  logic [`N_REGIONS_BITS-1:0] cmd_id;

  for (genvar i = 0; i < `N_REGIONS; i++) begin : g_queue
    region_queue region_queue_i (
      .aclk      (aclk),
      .aresetn   (aresetn),
      .req_valid (req_valid[i]),
      .req_ready (req_ready[i]),
      .req_op    (req_op[i]),
      .req_addr  (req_addr[i]),
      .req_wdata (req_wdata[i]),
      .q_valid   (q_valid[i]),
      .q_ready   (q_ready[i]),
      .q_op      (q_op[i]),
      .q_addr    (q_addr[i]),
      .q_wdata   (q_wdata[i])
    );
  end

  meta_arbiter #(
    .N_ID      (`N_REGIONS),
    .N_ID_BITS (`N_REGIONS_BITS)
  ) meta_arbiter_i (
    .aclk    (aclk),
    .aresetn (aresetn),
    .s_valid (q_valid),
    .s_ready (q_ready),
    .s_op    (q_op),
    .s_addr  (q_addr),
    .s_wdata (q_wdata),
    .m_valid (cmd_valid),
    .m_ready (cmd_ready),
    .m_op    (cmd_op),
    .m_addr  (cmd_addr),
    .m_wdata (cmd_wdata),
    .id_out  (cmd_id)
  );

  mem_engine mem_engine_i (
    .aclk      (aclk),
    .aresetn   (aresetn),
    .cmd_valid (cmd_valid),
    .cmd_ready (cmd_ready),
    .cmd_op    (cmd_op),
    .cmd_addr  (cmd_addr),
    .cmd_wdata (cmd_wdata),
    .cmd_id    (cmd_id),
    .rsp_valid (rsp_valid),
    .rsp_id    (rsp_id),
    .rsp_data  (rsp_data)
  );

endmodule

// ==== tests/meta_subsystem_sva.sv ====
/*
 * Protocol checks for the metadata command subsystem.
 * Bound into the top level. Covers the reset values, the engine's
 * command handshake during reads and the one-cycle read response strobe.
 */

`include "meta_defs.svh"

module meta_subsystem_sva (
  input logic                     aclk,
  input logic                     aresetn,
  input logic [`N_REGIONS-1:0]    req_ready,
  input logic                     cmd_valid,
  input logic                     cmd_ready,
  input meta_pkg::opcode_t        cmd_op,
  input logic                     rsp_valid,
  input meta_pkg::engine_state_t  engine_state
);

  timeunit 1ns;
  timeprecision 1ps;

  import meta_pkg::*;

  int unsigned fail_count = 0; // read by the testbench for its verdict.

  logic rd_fire; // a read transfers into the engine at this edge.
  logic wr_fire;

  assign rd_fire = cmd_valid & cmd_ready & (cmd_op == OP_READ);
  assign wr_fire = cmd_valid & cmd_ready & (cmd_op == OP_WRITE);

  // one edge of reset leaves the queues empty and the engine quiet.
  a_reset_idle: assert property (@(posedge aclk) !aresetn |=> (!rsp_valid && req_ready == '1))
    else begin fail_count++; $error("response or full queue right after reset"); end

  // the response strobe never lasts two cycles.
  a_rsp_one_cycle: assert property (@(posedge aclk) disable iff (!aresetn)
    rsp_valid |=> !rsp_valid)
    else begin fail_count++; $error("rsp_valid held for more than one cycle"); end

  // every read transfer is answered exactly two cycles later.
  a_read_to_rsp: assert property (@(posedge aclk) disable iff (!aresetn)
    $past(rd_fire, 2) |-> rsp_valid)
    else begin fail_count++; $error("read transfer without rsp_valid two cycles later"); end

  // and no response appears without such a read.
  a_rsp_from_read: assert property (@(posedge aclk) disable iff (!aresetn)
    rsp_valid |-> $past(rd_fire, 2))
    else begin fail_count++; $error("rsp_valid without a read two cycles earlier"); end

  // the engine takes no new command while a read is in flight.
  a_stall_during_read: assert property (@(posedge aclk) disable iff (!aresetn)
    ($past(rd_fire) || $past(rd_fire, 2)) |-> !cmd_ready)
    else begin fail_count++; $error("cmd_ready high during a read"); end

  a_write_stays_idle: assert property (@(posedge aclk) disable iff (!aresetn)
    wr_fire |=> engine_state == ST_IDLE) // writes finish in one edge.
    else begin fail_count++; $error("engine left idle after a write"); end

endmodule

bind meta_subsystem_top meta_subsystem_sva meta_subsystem_sva_i (
  .aclk         (aclk),
  .aresetn      (aresetn),
  .req_ready    (req_ready),
  .cmd_valid    (cmd_valid),
  .cmd_ready    (cmd_ready),
  .cmd_op       (cmd_op),
  .rsp_valid    (rsp_valid),
  .engine_state (mem_engine_i.state)
);

// ==== tests/tb_meta_subsystem.sv ====
/*
 * Testbench for the metadata command subsystem.
 * Drives the four region request ports with LFSR stimulus, keeps a model
 * of the shared memory and of each region's outstanding reads, and checks
 * every read response, the arbitration order and the back-pressure.
 */

`include "meta_defs.svh"

module tb_meta_subsystem;

  timeunit 1ns;
  timeprecision 1ps;

  import meta_pkg::*;

  localparam int ACCEPT_TIMEOUT = 200;  // cycles a request may wait for req_ready.
  localparam int DRAIN_TIMEOUT  = 2000;
  localparam int MIX_CMDS       = 12;   // commands per region in the mixed test.
  localparam int BURST_READS    = 12;

  logic                                  aclk = 1'b0;
  logic                                  aresetn;
  logic [`N_REGIONS-1:0]                 req_valid;
  logic [`N_REGIONS-1:0]                 req_ready;
  opcode_t [`N_REGIONS-1:0]              req_op;
  logic [`N_REGIONS-1:0][`ADDR_BITS-1:0] req_addr;
  logic [`N_REGIONS-1:0][`DATA_BITS-1:0] req_wdata;
  logic                                  rsp_valid;
  logic [`N_REGIONS_BITS-1:0]            rsp_id;
  logic [`DATA_BITS-1:0]                 rsp_data;

  // granted command at the engine, watched to follow the order of execution.
  logic                       eng_valid;
  logic                       eng_ready;
  opcode_t                    eng_op;
  logic [`ADDR_BITS-1:0]      eng_addr;
  logic [`DATA_BITS-1:0]      eng_wdata;
  logic [`N_REGIONS_BITS-1:0] eng_id;

  logic [`DATA_BITS-1:0]      model_mem [`MEM_WORDS];  // what the shared memory should hold.
  logic [`DATA_BITS-1:0]      exp_q [`N_REGIONS][$];   // expected read data, per region.
  logic [`N_REGIONS_BITS-1:0] rsp_ids [$];             // every response id in arrival order.
  logic [`DATA_BITS-1:0]      exp_data;

  // commands each region handed to its queue, in the order they were accepted.
  opcode_t               sent_op    [`N_REGIONS][$];
  logic [`ADDR_BITS-1:0] sent_addr  [`N_REGIONS][$];
  logic [`DATA_BITS-1:0] sent_wdata [`N_REGIONS][$];
  opcode_t               exp_op;
  logic [`ADDR_BITS-1:0] exp_addr;
  logic [`DATA_BITS-1:0] exp_wdata;

  int rsp_total      = 0;
  int reads_accepted = 0;
  int mon_errors     = 0;
  int errors         = 0;
  int tests_run      = 0;
  int tests_failed   = 0;

  logic [`N_REGIONS-1:0] ready_low_seen; // a requester found its queue full.
  logic [15:0]           lfsr = 16'd43;

  opcode_t               stim_op   [`N_REGIONS][MIX_CMDS];
  logic [`ADDR_BITS-1:0] stim_addr [`N_REGIONS][MIX_CMDS];
  logic [`DATA_BITS-1:0] stim_data [`N_REGIONS][MIX_CMDS];
  logic                  stim_gap  [`N_REGIONS][MIX_CMDS]; // idle cycle after the command.

  meta_subsystem_top meta_subsystem_top_i (
    .aclk      (aclk),
    .aresetn   (aresetn),
    .req_valid (req_valid),
    .req_ready (req_ready),
    .req_op    (req_op),
    .req_addr  (req_addr),
    .req_wdata (req_wdata),
    .rsp_valid (rsp_valid),
    .rsp_id    (rsp_id),
    .rsp_data  (rsp_data)
  );

  assign eng_valid = meta_subsystem_top_i.cmd_valid;
  assign eng_ready = meta_subsystem_top_i.cmd_ready;
  assign eng_op    = meta_subsystem_top_i.cmd_op;
  assign eng_addr  = meta_subsystem_top_i.cmd_addr;
  assign eng_wdata = meta_subsystem_top_i.cmd_wdata;
  assign eng_id    = meta_subsystem_top_i.cmd_id;

  always #10 aclk = ~aclk; // 20 ns period.

  // 16-bit Fibonacci LFSR with taps 16, 14, 13, 11. Each bit taken is one step.
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    logic        fb;
    r = '0;
    for (int i = 0; i < n; i++) begin
      fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
      lfsr = {lfsr[14:0], fb};
      r    = {r[30:0], fb};
    end
    return r;
  endfunction

  function automatic opcode_t rand_op();
    return (rand_bits(1) != 32'd0) ? OP_WRITE : OP_READ;
  endfunction

  function automatic int total_errors();
    return errors + mon_errors + int'(meta_subsystem_top_i.meta_subsystem_sva_i.fail_count);
  endfunction

  // engine signals only move after a rising edge, so the falling edge sees them settled.
  // a transfer seen here completes at the next rising edge.
  always @(negedge aclk) begin
    if (aresetn) begin
      if (eng_valid && eng_ready) begin
        if (sent_op[eng_id].size() == 0) begin
          mon_errors++;
          $display("region %0d command reached the engine but was never sent", eng_id);
        end else begin
          // each region's commands reach the engine unchanged and in order.
          exp_op    = sent_op[eng_id].pop_front();
          exp_addr  = sent_addr[eng_id].pop_front();
          exp_wdata = sent_wdata[eng_id].pop_front();
          assert (eng_op == exp_op) else begin
            mon_errors++;
            $display("FAIL cmd_op: got %h expected %h", eng_op, exp_op);
          end
          assert (eng_addr == exp_addr) else begin
            mon_errors++;
            $display("FAIL cmd_addr: got %h expected %h", eng_addr, exp_addr);
          end
          assert (exp_op == OP_READ || eng_wdata == exp_wdata) else begin
            mon_errors++;
            $display("FAIL cmd_wdata: got %h expected %h", eng_wdata, exp_wdata);
          end
          if (exp_op == OP_WRITE) begin
            model_mem[exp_addr] = exp_wdata;
          end else begin
            exp_q[eng_id].push_back(model_mem[exp_addr]); // read sees all earlier writes.
          end
        end
      end
      if (rsp_valid) begin
        rsp_ids.push_back(rsp_id);
        rsp_total++;
        assert (exp_q[rsp_id].size() != 0) else begin
          mon_errors++;
          $display("response for region %0d arrived with no read outstanding", rsp_id);
        end
        if (exp_q[rsp_id].size() != 0) begin
          exp_data = exp_q[rsp_id].pop_front(); // each region's reads stay in order.
          assert (rsp_data == exp_data) else begin
            mon_errors++;
            $display("FAIL rsp_data: got %h expected %h", rsp_data, exp_data);
          end
        end
      end
    end
  end

  task automatic apply_reset();
    aresetn = 1'b0;
    repeat (3) @(posedge aclk);
    @(negedge aclk);
    aresetn = 1'b1;
  endtask

  // called on a falling edge. Returns on the falling edge after the transfer, valid still high.
  task automatic send(input int r, input opcode_t op, input logic [`ADDR_BITS-1:0] addr,
                      input logic [`DATA_BITS-1:0] wdata);
    int waited;
    waited       = 0;
    req_valid[r] = 1'b1;
    req_op[r]    = op;
    req_addr[r]  = addr;
    req_wdata[r] = wdata;
    while (!req_ready[r] && waited < ACCEPT_TIMEOUT) begin
      ready_low_seen[r] = 1'b1;
      @(negedge aclk);
      waited++;
    end
    if (req_ready[r]) begin
      sent_op[r].push_back(op);
      sent_addr[r].push_back(addr);
      sent_wdata[r].push_back(wdata);
      if (op == OP_READ) begin
        reads_accepted++;
      end
      @(negedge aclk); // the rising edge in between took the command.
    end else begin
      errors++;
      $display("timeout: region %0d command not accepted in %0d cycles", r, ACCEPT_TIMEOUT);
    end
  endtask

  task automatic drive_region(input int r);
    for (int k = 0; k < MIX_CMDS; k++) begin
      send(r, stim_op[r][k], stim_addr[r][k], stim_data[r][k]);
      if (stim_gap[r][k]) begin
        req_valid[r] = 1'b0;
        @(negedge aclk);
      end
    end
    req_valid[r] = 1'b0;
  endtask

  // waits until every accepted read is answered and the queues and engine are empty.
  task automatic drain();
    int waited;
    waited = 0;
    while (!(rsp_total == reads_accepted && meta_subsystem_top_i.q_valid == '0 && eng_ready)
           && waited < DRAIN_TIMEOUT) begin
      @(negedge aclk);
      waited++;
    end
    if (rsp_total != reads_accepted) begin
      errors++;
      $display("timeout: %0d reads still unanswered after %0d cycles",
               reads_accepted - rsp_total, DRAIN_TIMEOUT);
    end
  endtask

  task automatic report(input int num, input string name, input int errs_before);
    int errs;
    errs = total_errors() - errs_before;
    tests_run++;
    if (errs == 0) begin
      $display("test %0d %s: ok", num, name);
    end else begin
      tests_failed++;
      $display("test %0d %s: %0d errors", num, name, errs);
    end
  endtask

  initial begin
    int base;
    int first;
    int reads_before;
    int rsp_before;
    req_valid      = '0;
    req_addr       = '0;
    req_wdata      = '0;
    ready_low_seen = '0;
    for (int r = 0; r < `N_REGIONS; r++) begin
      req_op[r] = OP_READ;
    end

    base = total_errors();
    apply_reset();
    assert (rsp_valid == 1'b0) else begin
      errors++;
      $display("FAIL rsp_valid: got %h expected %h", rsp_valid, 1'b0);
    end
    assert (req_ready == '1) else begin
      errors++;
      $display("FAIL req_ready: got %h expected %h", req_ready, 4'hf);
    end
    report(1, "reset values", base);

    // region 0 fills the whole memory, reading each word back.
    base  = total_errors();
    first = rsp_ids.size();
    for (int a = 0; a < `MEM_WORDS; a++) begin
      send(0, OP_WRITE, `ADDR_BITS'(a), `DATA_BITS'(rand_bits(16)));
      send(0, OP_READ, `ADDR_BITS'(a), '0);
    end
    req_valid[0] = 1'b0;
    drain();
    assert (rsp_ids.size() - first == `MEM_WORDS) else begin
      errors++;
      $display("FAIL response count: got %h expected %h", rsp_ids.size() - first, `MEM_WORDS);
    end
    for (int i = first; i < rsp_ids.size(); i++) begin
      assert (rsp_ids[i] == '0) else begin
        errors++;
        $display("FAIL rsp_id: got %h expected %h", rsp_ids[i], 2'h0);
      end
    end
    report(2, "region 0 write and read sweep", base);

    // the stimulus is drawn up front so the parallel drivers don't share the LFSR.
    base = total_errors();
    for (int r = 0; r < `N_REGIONS; r++) begin
      for (int k = 0; k < MIX_CMDS; k++) begin
        stim_op[r][k]   = rand_op();
        stim_addr[r][k] = `ADDR_BITS'(rand_bits(`ADDR_BITS));
        stim_data[r][k] = `DATA_BITS'(rand_bits(`DATA_BITS));
        stim_gap[r][k]  = (rand_bits(1) != 32'd0);
      end
    end
    fork
      drive_region(0);
      drive_region(1);
      drive_region(2);
      drive_region(3);
    join
    drain();
    report(3, "random traffic from all regions", base);

    // a fresh reset puts the round-robin pointer back on region 0.
    base = total_errors();
    for (int r = 0; r < `N_REGIONS; r++) begin
      for (int k = 0; k < 3; k++) begin
        stim_addr[r][k] = `ADDR_BITS'(rand_bits(`ADDR_BITS));
      end
    end
    apply_reset();
    first = rsp_ids.size();
    for (int k = 0; k < 3; k++) begin
      fork
        send(0, OP_READ, stim_addr[0][k], '0);
        send(1, OP_READ, stim_addr[1][k], '0);
        send(2, OP_READ, stim_addr[2][k], '0);
        send(3, OP_READ, stim_addr[3][k], '0);
      join
    end
    req_valid = '0;
    drain();
    assert (rsp_ids.size() - first == 3 * `N_REGIONS) else begin
      errors++;
      $display("FAIL response count: got %h expected %h", rsp_ids.size() - first, 12);
    end
    for (int i = 0; i < rsp_ids.size() - first; i++) begin
      assert (rsp_ids[first + i] == `N_REGIONS_BITS'(i % `N_REGIONS)) else begin
        errors++;
        $display("FAIL rsp_id: got %h expected %h", rsp_ids[first + i], i % `N_REGIONS);
      end
    end
    report(4, "round-robin order", base);

    // reads back to back from one region outrun the engine and fill its queue.
    base           = total_errors();
    ready_low_seen = '0;
    reads_before   = reads_accepted;
    rsp_before     = rsp_total;
    for (int k = 0; k < BURST_READS; k++) begin
      send(2, OP_READ, `ADDR_BITS'(rand_bits(`ADDR_BITS)), '0);
    end
    req_valid[2] = 1'b0;
    drain();
    assert (ready_low_seen[2]) else begin
      errors++;
      $display("req_ready of region 2 never dropped during the read burst");
    end
    assert (rsp_total - rsp_before == reads_accepted - reads_before) else begin
      errors++;
      $display("FAIL response count: got %h expected %h",
               rsp_total - rsp_before, reads_accepted - reads_before);
    end
    report(5, "read burst back-pressure", base);

    $display("tests run %0d, tests with errors %0d, check errors %0d, assertion failures %0d",
             tests_run, tests_failed, errors + mon_errors,
             meta_subsystem_top_i.meta_subsystem_sva_i.fail_count);
    if (tests_failed == 0 && total_errors() == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// ==== sim.f ====
+incdir+design
design/meta_pkg.sv
design/region_queue.sv
design/meta_arbiter.sv
design/mem_engine.sv
design/meta_subsystem_top.sv
tests/meta_subsystem_sva.sv
tests/tb_meta_subsystem.sv

// ==== run.sh ====
#!/bin/sh
# builds the metadata subsystem testbench with Verilator and runs it.
# the exit status follows the pass line in the simulation output.
# the error limit lets the testbench reach its own verdict after an assertion fires.
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_meta_subsystem -f sim.f -o tb_sim \
  || { echo "build failed"; exit 1; }
out=$(./obj_dir/tb_sim +verilator+error+limit+1000)
echo "$out"
echo "$out" | grep -qx "Test passed" && exit 0 || exit 1
